// ==== run.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bp_tb -f vlog.f -o bp_sim
./obj_dir/bp_sim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi

// ==== verification/bp_tb_model.svh ====
// Reference model for the predictor testbench
// Mirror of PHT, BTB, history and register block
// Galois LFSR for random stimulus
`ifndef BP_TB_MODEL_SVH
`define BP_TB_MODEL_SVH

// Mirror state, stepped at each rising edge
logic [1:0]  m_pht [BP_PHT_ENTRIES];
logic        m_btb_valid [BP_BTB_ENTRIES];
logic [7:0]  m_btb_tag [BP_BTB_ENTRIES];
logic [31:0] m_btb_target [BP_BTB_ENTRIES];
logic [7:0]  m_ghr;
logic        m_enable;
logic        m_flush_pending;
// Event counters by register address, slot 0 unused
logic [31:0] m_counts [4];
logic [31:0] lfsr_state;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_bits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return value;
endfunction

// Saturate at 0 and 3
function automatic logic [1:0] counter_step(logic [1:0] state, logic taken);
    if (taken) begin
        return (state == 2'd3) ? state : state + 2'd1;
    end
    return (state == 2'd0) ? state : state - 2'd1;
endfunction

function automatic void clear_tables();
    for (int i = 0; i < BP_PHT_ENTRIES; i++) begin
        m_pht[i] = 2'd0;
    end
    for (int i = 0; i < BP_BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
    end
    m_ghr = '0;
endfunction

function automatic void reset_model();
    clear_tables();
    m_enable        = 1'b1;
    m_flush_pending = 1'b0;
    m_counts        = '{default: '0};
endfunction

// PHT index is PC bits 9..2 XOR history, BTB uses index 7..2 and tag 15..8
function automatic logic expected_taken(logic [31:0] pc);
    logic [5:0] entry;
    entry = pc[7:2];
    return m_enable && m_pht[pc[9:2] ^ m_ghr][1] && m_btb_valid[entry]
        && (m_btb_tag[entry] == pc[15:8]);
endfunction

function automatic logic [31:0] expected_target(logic [31:0] pc);
    return expected_taken(pc) ? m_btb_target[pc[7:2]] : pc + 32'd4;
endfunction

function automatic logic [31:0] expected_csr(logic [1:0] addr);
    return (addr == BP_CSR_CTRL) ? {31'b0, m_enable} : m_counts[addr];
endfunction

// One clock edge of the whole predictor, from the inputs held this cycle
function automatic void advance_model();
    logic       pred_dir;
    logic       ctrl_write;
    logic [7:0] train_index;
    logic [3:0] strobe;
    pred_dir    = pred_valid && expected_taken(pred_pc);
    ctrl_write  = csr_write && (csr_addr == BP_CSR_CTRL);
    train_index = train_pc[9:2] ^ train_ghr;
    strobe      = {train_valid && train_mispredict, train_valid, pred_valid, 1'b0};
    // Write to a counter clears it, otherwise count
    for (int a = 1; a < 4; a++) begin
        if (csr_write && (csr_addr == 2'(a))) begin
            m_counts[a] = '0;
        end else if (strobe[a]) begin
            m_counts[a] = m_counts[a] + 32'd1;
        end
    end
    if (m_flush_pending) begin
        clear_tables();
    end else begin
        if (train_valid) begin
            m_pht[train_index] = counter_step(m_pht[train_index], train_taken);
        end
        if (train_valid && train_taken) begin
            m_btb_valid[train_pc[7:2]]  = 1'b1;
            m_btb_tag[train_pc[7:2]]    = train_pc[15:8];
            m_btb_target[train_pc[7:2]] = train_target;
        end
        // Recovery beats the speculative shift
        if (train_valid && train_mispredict) begin
            m_ghr = {train_ghr[6:0], train_taken};
        end else if (pred_valid) begin
            m_ghr = {m_ghr[6:0], pred_dir};
        end
    end
    if (ctrl_write) begin
        m_enable = csr_wdata[0];
    end
    m_flush_pending = ctrl_write && csr_wdata[1];
endfunction

`endif

// ==== verification/bp_tb.sv ====
// Branch predictor testbench
// Clock and reset, directed and random stimulus
// Per cycle comparison against the reference model, test report
`timescale 1ns/1ps

module bp_tb import bp_params_pkg::*; ();

    logic        clock;
    logic        reset;
    logic        pred_valid;
    logic [31:0] pred_pc;
    logic        train_valid;
    logic [31:0] train_pc;
    logic [7:0]  train_ghr;
    logic        train_taken;
    logic [31:0] train_target;
    logic        train_mispredict;
    logic        csr_write;
    logic [1:0]  csr_addr;
    logic [31:0] csr_wdata;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic [7:0]  pred_ghr;
    logic [31:0] csr_rdata;

    string test_name;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    test_count;

    `include "bp_tb_model.svh"

    bp_top bp_top_i (
        .clock_i            (clock),
        .reset_i            (reset),
        .pred_valid_i       (pred_valid),
        .pred_pc_i          (pred_pc),
        .train_valid_i      (train_valid),
        .train_pc_i         (train_pc),
        .train_ghr_i        (train_ghr),
        .train_taken_i      (train_taken),
        .train_target_i     (train_target),
        .train_mispredict_i (train_mispredict),
        .csr_write_i        (csr_write),
        .csr_addr_i         (csr_addr),
        .csr_wdata_i        (csr_wdata),
        .pred_taken_o       (pred_taken),
        .pred_target_o      (pred_target),
        .pred_ghr_o         (pred_ghr),
        .csr_rdata_o        (csr_rdata)
    );

    // 20 ns period
    always #10 clock = ~clock;

    // Mirror steps on the same edge as the DUT
    always @(posedge clock) begin
        if (reset) begin
            reset_model();
        end else begin
            advance_model();
        end
    end

    //////////////////////////////
    // Comparison
    //////////////////////////////

    // Inputs and combinational outputs are settled at the falling edge
    always @(negedge clock) begin
        if (!reset && pred_valid) begin
            check_value("pred_taken", 32'(pred_taken), 32'(expected_taken(pred_pc)));
            check_value("pred_target", pred_target, expected_target(pred_pc));
            check_value("pred_ghr", 32'(pred_ghr), 32'(m_ghr));
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        test_checks++;
        assert (actual === expected) else begin
            test_errors++;
            $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic drive_cycle(input logic p_valid, input logic [31:0] p_pc,
                               input logic t_valid, input logic [31:0] t_pc,
                               input logic [7:0] t_ghr, input logic t_taken,
                               input logic [31:0] t_target, input logic t_miss);
        @(posedge clock);
        pred_valid       <= p_valid;
        pred_pc          <= p_pc;
        train_valid      <= t_valid;
        train_pc         <= t_pc;
        train_ghr        <= t_ghr;
        train_taken      <= t_taken;
        train_target     <= t_target;
        train_mispredict <= t_miss;
        csr_write        <= 1'b0;
    endtask

    task automatic write_csr(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clock);
        pred_valid  <= 1'b0;
        train_valid <= 1'b0;
        csr_write   <= 1'b1;
        csr_addr    <= addr;
        csr_wdata   <= data;
    endtask

    // Idle cycle that holds the address for a falling edge read
    task automatic read_csr_check(input logic [1:0] addr, input string what);
        @(posedge clock);
        pred_valid  <= 1'b0;
        train_valid <= 1'b0;
        csr_write   <= 1'b0;
        csr_addr    <= addr;
        @(negedge clock);
        check_value(what, csr_rdata, expected_csr(addr));
    endtask

    task automatic wait_ctrl_reads_one(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            pred_valid  <= 1'b0;
            train_valid <= 1'b0;
            csr_write   <= 1'b0;
            csr_addr    <= BP_CSR_CTRL;
            @(negedge clock);
            cycles++;
        end while (csr_rdata !== 32'd1 && cycles < limit);
        if (csr_rdata !== 32'd1) begin
            $display("timeout: control register did not read 1 within %0d cycles", limit);
            $display("Checks failed");
            $finish;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_count++;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [31:0] pool [16];
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        clock = 1'b0;
        reset = 1'b1;
        {pred_valid, train_valid, train_taken, train_mispredict, csr_write} = '0;
        {pred_pc, train_pc, train_ghr, train_target, csr_addr, csr_wdata} = '0;
        {total_checks, total_errors, test_count} = '0;
        lfsr_state = 32'hdbc0;
        // Small pool of word addresses so entries get reused
        for (int i = 0; i < 16; i++) begin
            pool[i] = lfsr_bits(14) << 2;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        start_test("reset_state");
        wait_ctrl_reads_one(10);
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, pool[i], 1'b0, '0, '0, 1'b0, '0, 1'b0);
        end
        read_csr_check(BP_CSR_CTRL, "ctrl");
        finish_test();

        // History is still 0, so snapshot 0 matches the next request
        start_test("taken_training");
        pc_a = pool[0];
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_8000, 1'b0);
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_8000, 1'b0);
        drive_cycle(1'b1, pc_a, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("trained_taken", 32'(pred_taken), 32'd1);
        check_value("trained_target", pred_target, 32'h0000_8000);
        // Snapshot 0 keeps retrained counters in reach of the requests
        for (int i = 0; i < 40; i++) begin
            drive_cycle(1'(lfsr_bits(1)), pool[lfsr_bits(4)], 1'(lfsr_bits(1)),
                        pool[lfsr_bits(4)], 8'h00, 1'(lfsr_bits(1)),
                        lfsr_bits(14) << 2, 1'b0);
        end
        finish_test();

        // Request every cycle with recovery on about half of them
        start_test("history_recovery");
        for (int i = 0; i < 24; i++) begin
            drive_cycle(1'b1, pool[lfsr_bits(4)], 1'b1, pool[lfsr_bits(4)],
                        8'(lfsr_bits(8)), 1'(lfsr_bits(1)), lfsr_bits(14) << 2,
                        1'(lfsr_bits(1)));
        end
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, pool[lfsr_bits(4)], 1'b0, '0, '0, 1'b0, '0, 1'b0);
        end
        finish_test();

        // Bit 10 is a tag bit outside both indexes
        start_test("tag_alias");
        pc_a = pool[2];
        pc_b = pc_a ^ 32'h0000_0400;
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b0, '0, 1'b1);
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_4000, 1'b0);
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_4000, 1'b0);
        drive_cycle(1'b1, pc_b, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("alias_taken", 32'(pred_taken), 32'd0);
        check_value("alias_target", pred_target, pc_b + 32'd4);
        drive_cycle(1'b1, pc_a, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("owner_taken", 32'(pred_taken), 32'd1);
        check_value("owner_target", pred_target, 32'h0000_4000);
        finish_test();

        start_test("enable_flush");
        write_csr(BP_CSR_CTRL, 32'd0);
        // Snapshot 8'h80 clears history and trains a counter away from pc_a
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h80, 1'b0, '0, 1'b1);
        // pc_a still hits with a taken counter
        drive_cycle(1'b1, pc_a, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("disabled_taken", 32'(pred_taken), 32'd0);
        check_value("disabled_target", pred_target, pc_a + 32'd4);
        for (int i = 0; i < 20; i++) begin
            drive_cycle(1'b1, pool[lfsr_bits(4)], 1'b1, pool[lfsr_bits(4)],
                        8'(lfsr_bits(8)), 1'(lfsr_bits(1)), lfsr_bits(14) << 2, 1'b0);
        end
        read_csr_check(BP_CSR_CTRL, "ctrl_disabled");
        write_csr(BP_CSR_CTRL, 32'd1);
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, pool[i], 1'b0, '0, '0, 1'b0, '0, 1'b0);
        end
        // Give the flush a taken entry and a nonzero history to clear
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h80, 1'b0, '0, 1'b1);
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_4000, 1'b0);
        drive_cycle(1'b0, '0, 1'b1, pc_a, 8'h00, 1'b1, 32'h0000_4000, 1'b0);
        drive_cycle(1'b1, pc_a, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("before_flush_taken", 32'(pred_taken), 32'd1);
        // Enable plus flush where the flush bit reads back 0
        write_csr(BP_CSR_CTRL, 32'd3);
        wait_ctrl_reads_one(8);
        drive_cycle(1'b1, pc_a, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);
        check_value("flushed_taken", 32'(pred_taken), 32'd0);
        check_value("flushed_target", pred_target, pc_a + 32'd4);
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, pool[i], 1'b0, '0, '0, 1'b0, '0, 1'b0);
            @(negedge clock);
            check_value("flushed_taken", 32'(pred_taken), 32'd0);
            check_value("flushed_target", pred_target, pool[i] + 32'd4);
        end
        finish_test();

        start_test("event_counters");
        for (int a = 1; a < 4; a++) begin
            read_csr_check(2'(a), "count");
            write_csr(2'(a), 32'd0);
            read_csr_check(2'(a), "cleared_count");
            check_value("cleared_zero", csr_rdata, 32'd0);
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/bp_btb.sv ====
// Direct mapped branch target buffer
// Tag compare, final taken decision and next fetch target
`timescale 1ns/1ps

module bp_btb import bp_params_pkg::*, bp_types_pkg::*; (
    input  logic            clock_i,
    input  logic            reset_i,
    input  logic            flush_i,
    input  logic            enable_i,
    input  logic            pht_taken_i,
    bp_predict_if.btb       predict,
    bp_train_if.btb         train
);

    bp_btb_entry_t btb_q [BP_BTB_ENTRIES];
    bp_btb_entry_t pred_entry;
    bp_pc_u        pred_pc;
    bp_pc_u        train_pc;
    logic          pred_hit;

    assign pred_pc  = predict.pc;
    assign train_pc = train.pc;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    assign pred_entry = btb_q[pred_pc.fields.index];
    assign pred_hit   = pred_entry.valid && (pred_entry.tag == pred_pc.fields.tag);

    // Taken needs enable, counter and a tag hit
    assign predict.taken  = enable_i && pht_taken_i && pred_hit;
    // Fall through to the next word otherwise
    assign predict.target = predict.taken ? pred_entry.target : predict.pc + 32'd4;

    //////////////////////////////
    // Allocation on taken retire
    //////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i || flush_i) begin
            // Clear marks every entry invalid
            for (int i = 0; i < BP_BTB_ENTRIES; i++) begin
                btb_q[i].valid <= 1'b0;
            end
        end else if (train.valid && train.actual_taken) begin
            btb_q[train_pc.fields.index].valid  <= 1'b1;
            btb_q[train_pc.fields.index].tag    <= train_pc.fields.tag;
            btb_q[train_pc.fields.index].target <= train.actual_target;
        end
    end

endmodule

// ==== verilog/bp_csr.sv ====
// Predictor register block
// Control word with enable and flush pulse
// Prediction, training and mispredict event counters
`timescale 1ns/1ps

module bp_csr import bp_params_pkg::*; (
    input  logic                         clock_i,
    input  logic                         reset_i,
    input  logic                         csr_write_i,
    input  logic [BP_CSR_ADDR_WIDTH-1:0] csr_addr_i,
    input  logic [BP_COUNT_WIDTH-1:0]    csr_wdata_i,
    bp_train_if.csr                      train,
    input  logic                         pred_valid_i,
    output logic [BP_COUNT_WIDTH-1:0]    csr_rdata_o,
    output logic                         enable_o,
    output logic                         flush_o
);

    logic                      enable_q;
    logic                      flush_q;
    logic [BP_COUNT_WIDTH-1:0] pred_count_q;
    logic [BP_COUNT_WIDTH-1:0] train_count_q;
    logic [BP_COUNT_WIDTH-1:0] miss_count_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            enable_q      <= 1'b1;
            flush_q       <= 1'b0;
            pred_count_q  <= '0;
            train_count_q <= '0;
            miss_count_q  <= '0;
        end else begin
            // Flush lasts one cycle after the write
            flush_q <= csr_write_i && (csr_addr_i == BP_CSR_CTRL) && csr_wdata_i[1];
            if (csr_write_i && (csr_addr_i == BP_CSR_CTRL)) begin
                enable_q <= csr_wdata_i[0];
            end
            // Write clears, otherwise count the strobe
            if (csr_write_i && (csr_addr_i == BP_CSR_PRED_COUNT)) begin
                pred_count_q <= '0;
            end else if (pred_valid_i) begin
                pred_count_q <= pred_count_q + 1'b1;
            end
            if (csr_write_i && (csr_addr_i == BP_CSR_TRAIN_COUNT)) begin
                train_count_q <= '0;
            end else if (train.valid) begin
                train_count_q <= train_count_q + 1'b1;
            end
            if (csr_write_i && (csr_addr_i == BP_CSR_MISS_COUNT)) begin
                miss_count_q <= '0;
            end else if (train.valid && train.mispredict) begin
                miss_count_q <= miss_count_q + 1'b1;
            end
        end
    end

    // Read mux, flush bit always reads 0
    always_comb begin
        case (csr_addr_i)
            BP_CSR_CTRL:        csr_rdata_o = {{(BP_COUNT_WIDTH-1){1'b0}}, enable_q};
            BP_CSR_PRED_COUNT:  csr_rdata_o = pred_count_q;
            BP_CSR_TRAIN_COUNT: csr_rdata_o = train_count_q;
            default:            csr_rdata_o = miss_count_q;
        endcase
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

endmodule

// ==== verilog/bp_history.sv ====
// Global history register
// Speculative shift on prediction, restore on mispredicted retire
`timescale 1ns/1ps

module bp_history import bp_params_pkg::*; (
    input  logic            clock_i,
    input  logic            reset_i,
    input  logic            flush_i,
    bp_predict_if.history   predict,
    bp_train_if.history     train
);

    logic [BP_GHR_WIDTH-1:0] ghr_q;
    logic [BP_GHR_WIDTH-1:0] ghr_next;

    // Recovery outranks a same cycle fetch shift
    always_comb begin
        ghr_next = ghr_q;
        if (train.valid && train.mispredict) begin
            ghr_next = {train.ghr_snapshot[BP_GHR_WIDTH-2:0], train.actual_taken};
        end else if (predict.valid) begin
            ghr_next = {ghr_q[BP_GHR_WIDTH-2:0], predict.taken};
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i || flush_i) begin
            ghr_q <= '0;
        end else begin
            ghr_q <= ghr_next;
        end
    end

    // Registered value, state at cycle start
    assign predict.ghr_snapshot = ghr_q;

endmodule

// ==== verilog/bp_if.sv ====
// Predictor interfaces
// Fetch request with prediction result
// Retiring branch for training and recovery
`timescale 1ns/1ps

interface bp_predict_if import bp_params_pkg::*; ();

    // From fetch
    logic                    valid;
    logic [BP_PC_WIDTH-1:0]  pc;
    // Prediction result
    logic                    taken;
    logic [BP_PC_WIDTH-1:0]  target;
    // History at the start of this cycle
    logic [BP_GHR_WIDTH-1:0] ghr_snapshot;

    modport pht (input valid, input pc, input ghr_snapshot);
    modport btb (input pc, output taken, output target);
    modport history (input valid, input taken, output ghr_snapshot);

endinterface

interface bp_train_if import bp_params_pkg::*; ();

    logic                    valid;
    logic [BP_PC_WIDTH-1:0]  pc;
    // History seen when this branch was fetched
    logic [BP_GHR_WIDTH-1:0] ghr_snapshot;
    logic                    actual_taken;
    logic [BP_PC_WIDTH-1:0]  actual_target;
    logic                    mispredict;

    // All consumers only read the retire stream
    modport pht (input valid, input pc, input ghr_snapshot, input actual_taken);
    modport btb (input valid, input pc, input actual_taken, input actual_target);
    modport history (input valid, input ghr_snapshot, input actual_taken, input mispredict);
    modport csr (input valid, input mispredict);

endinterface

// ==== verilog/bp_params_pkg.sv ====
// Branch predictor parameters
// Table geometry, history width, program counter alignment
// Register map addresses and event counter width
package bp_params_pkg;

    //////////////////////////////
    // Predictor geometry
    //////////////////////////////

    // Global history length in bits
    localparam int BP_GHR_WIDTH     = 8;
    // PHT index width and depth
    localparam int BP_PHT_BITS      = 8;
    localparam int BP_PHT_ENTRIES   = 1 << BP_PHT_BITS;
    // Direct mapped BTB index width and depth
    localparam int BP_BTB_BITS      = 6;
    localparam int BP_BTB_ENTRIES   = 1 << BP_BTB_BITS;
    localparam int BP_BTB_TAG_BITS  = 8;
    // Word aligned fetch, low bits never index
    localparam int BP_PC_ALIGN_BITS = 2;
    localparam int BP_PC_WIDTH      = 32;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam int BP_CSR_ADDR_WIDTH = 2;
    localparam logic [BP_CSR_ADDR_WIDTH-1:0] BP_CSR_CTRL        = 2'd0;
    localparam logic [BP_CSR_ADDR_WIDTH-1:0] BP_CSR_PRED_COUNT  = 2'd1;
    localparam logic [BP_CSR_ADDR_WIDTH-1:0] BP_CSR_TRAIN_COUNT = 2'd2;
    localparam logic [BP_CSR_ADDR_WIDTH-1:0] BP_CSR_MISS_COUNT  = 2'd3;
    // Event counters and register data path
    localparam int BP_COUNT_WIDTH = 32;

endpackage

// ==== verilog/bp_pht.sv ====
// Gshare pattern history table
// Combinational direction lookup, saturating training at retire
`timescale 1ns/1ps

module bp_pht import bp_params_pkg::*, bp_types_pkg::*; (
    input  logic            clock_i,
    input  logic            reset_i,
    input  logic            flush_i,
    bp_predict_if.pht       predict,
    bp_train_if.pht         train,
    output logic            pht_taken_o
);

    bp_counter_e            pht_q [BP_PHT_ENTRIES];
    bp_pc_u                 pred_pc;
    bp_pc_u                 train_pc;
    logic [BP_PHT_BITS-1:0] pred_index;
    logic [BP_PHT_BITS-1:0] train_index;

    // Two bit saturating step
    function automatic bp_counter_e counter_next(bp_counter_e state, logic taken);
        bp_counter_e next_state;
        case (state)
            BP_STRONGLY_NOT_TAKEN: next_state = taken ? BP_WEAKLY_NOT_TAKEN : BP_STRONGLY_NOT_TAKEN;
            BP_WEAKLY_NOT_TAKEN:   next_state = taken ? BP_WEAKLY_TAKEN : BP_STRONGLY_NOT_TAKEN;
            BP_WEAKLY_TAKEN:       next_state = taken ? BP_STRONGLY_TAKEN : BP_WEAKLY_NOT_TAKEN;
            default:               next_state = taken ? BP_STRONGLY_TAKEN : BP_WEAKLY_TAKEN;
        endcase
        return next_state;
    endfunction

    // PC bits above alignment XOR history
    assign pred_pc     = predict.pc;
    assign train_pc    = train.pc;
    assign pred_index  = pred_pc.raw[BP_PC_ALIGN_BITS +: BP_PHT_BITS] ^ predict.ghr_snapshot;
    assign train_index = train_pc.raw[BP_PC_ALIGN_BITS +: BP_PHT_BITS] ^ train.ghr_snapshot;

    // Direction is the counter upper bit, only for a live request
    assign pht_taken_o = predict.valid & pht_q[pred_index][1];

    always_ff @(posedge clock_i) begin
        if (reset_i || flush_i) begin
            for (int i = 0; i < BP_PHT_ENTRIES; i++) begin
                pht_q[i] <= BP_STRONGLY_NOT_TAKEN;
            end
        end else if (train.valid) begin
            pht_q[train_index] <= counter_next(pht_q[train_index], train.actual_taken);
        end
    end

endmodule

// ==== verilog/bp_top.sv ====
// Branch predictor top level
// Port to interface binding, PHT, BTB, history and register block
`timescale 1ns/1ps

module bp_top import bp_params_pkg::*; (
    input  logic                         clock_i,
    input  logic                         reset_i,
    // Fetch request
    input  logic                         pred_valid_i,
    input  logic [BP_PC_WIDTH-1:0]       pred_pc_i,
    // Retire training
    input  logic                         train_valid_i,
    input  logic [BP_PC_WIDTH-1:0]       train_pc_i,
    input  logic [BP_GHR_WIDTH-1:0]      train_ghr_i,
    input  logic                         train_taken_i,
    input  logic [BP_PC_WIDTH-1:0]       train_target_i,
    input  logic                         train_mispredict_i,
    // Register access
    input  logic                         csr_write_i,
    input  logic [BP_CSR_ADDR_WIDTH-1:0] csr_addr_i,
    input  logic [BP_COUNT_WIDTH-1:0]    csr_wdata_i,
    // Prediction result
    output logic                         pred_taken_o,
    output logic [BP_PC_WIDTH-1:0]       pred_target_o,
    output logic [BP_GHR_WIDTH-1:0]      pred_ghr_o,
    output logic [BP_COUNT_WIDTH-1:0]    csr_rdata_o
);

    logic pht_taken;
    logic enable;
    logic flush;

    bp_predict_if predict_if ();
    bp_train_if   train_if ();

    //////////////////////////////
    // Ports into interfaces
    //////////////////////////////

    assign predict_if.valid      = pred_valid_i;
    assign predict_if.pc         = pred_pc_i;
    assign train_if.valid        = train_valid_i;
    assign train_if.pc           = train_pc_i;
    assign train_if.ghr_snapshot = train_ghr_i;
    assign train_if.actual_taken = train_taken_i;
    assign train_if.actual_target = train_target_i;
    assign train_if.mispredict   = train_mispredict_i;

    assign pred_taken_o  = predict_if.taken;
    assign pred_target_o = predict_if.target;
    assign pred_ghr_o    = predict_if.ghr_snapshot;

    bp_pht bp_pht_i (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .flush_i     (flush),
        .predict     (predict_if.pht),
        .train       (train_if.pht),
        .pht_taken_o (pht_taken)
    );

    bp_btb bp_btb_i (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .flush_i     (flush),
        .enable_i    (enable),
        .pht_taken_i (pht_taken),
        .predict     (predict_if.btb),
        .train       (train_if.btb)
    );

    bp_history bp_history_i (
        .clock_i (clock_i),
        .reset_i (reset_i),
        .flush_i (flush),
        .predict (predict_if.history),
        .train   (train_if.history)
    );

    bp_csr bp_csr_i (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .csr_write_i  (csr_write_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .train        (train_if.csr),
        .pred_valid_i (pred_valid_i),
        .csr_rdata_o  (csr_rdata_o),
        .enable_o     (enable),
        .flush_o      (flush)
    );

endmodule

// ==== verilog/bp_types_pkg.sv ====
// Branch predictor types
// Two bit counter state, BTB entry layout
// Program counter union with raw and field views
package bp_types_pkg;

    import bp_params_pkg::*;

    // Saturating counter, upper bit gives the direction
    typedef enum logic [1:0] {
        BP_STRONGLY_NOT_TAKEN = 2'd0,
        BP_WEAKLY_NOT_TAKEN   = 2'd1,
        BP_WEAKLY_TAKEN       = 2'd2,
        BP_STRONGLY_TAKEN     = 2'd3
    } bp_counter_e;

    // One BTB line, 41 bits
    typedef struct packed {
        logic                       valid;
        logic [BP_BTB_TAG_BITS-1:0] tag;
        logic [BP_PC_WIDTH-1:0]     target;
    } bp_btb_entry_t;

    // Bits above tag, index and alignment
    localparam int BP_PC_UNUSED_BITS =
        BP_PC_WIDTH - BP_BTB_TAG_BITS - BP_BTB_BITS - BP_PC_ALIGN_BITS;

    // BTB split of the fetch address
    typedef struct packed {
        logic [BP_PC_UNUSED_BITS-1:0] unused;
        logic [BP_BTB_TAG_BITS-1:0]   tag;
        logic [BP_BTB_BITS-1:0]       index;
        logic [BP_PC_ALIGN_BITS-1:0]  align;
    } bp_pc_fields_t;

    // Same word seen whole by the PHT, split by the BTB
    typedef union packed {
        logic [BP_PC_WIDTH-1:0] raw;
        bp_pc_fields_t          fields;
    } bp_pc_u;

endpackage

// ==== vlog.f ====
+incdir+verification
verilog/bp_params_pkg.sv
verilog/bp_types_pkg.sv
verilog/bp_if.sv
verilog/bp_pht.sv
verilog/bp_btb.sv
verilog/bp_history.sv
verilog/bp_csr.sv
verilog/bp_top.sv
verification/bp_tb.sv
